// ==== Bender.yml ====
package:
  name: baseball

sources:
  - files:
      - rtl/baseball_pkg.sv
      - rtl/key_capture.sv
      - rtl/seed_regs.sv
      - rtl/secret_gen.sv
      - rtl/game_fsm.sv
      - rtl/report_credit.sv
      - rtl/baseball_top.sv
  - target: simulation
    files:
      - verification/baseball_tb.sv

// ==== baseball.f ====
rtl/baseball_pkg.sv
rtl/key_capture.sv
rtl/seed_regs.sv
rtl/secret_gen.sv
rtl/game_fsm.sv
rtl/report_credit.sv
rtl/baseball_top.sv
verification/baseball_tb.sv

// ==== rtl/baseball_pkg.sv ====
// shared widths, limits, report format and FSM states for the number baseball design
package baseball_pkg;

  localparam int SEED_DIGITS    = 4;
  localparam int GUESS_DIGITS   = 3;
  localparam int MAX_ATTEMPTS   = 10;
  localparam int REPORT_CREDITS = 2;   // granted by the display side after reset
  localparam int KEYS           = 10;

  // one-hot keypad, bit n is digit n
  typedef logic [KEYS-1:0] keypad_t;

  typedef logic [3:0] digit_t;

  // strike or ball count, 0..3
  typedef logic [1:0] count_t;

  typedef logic [3:0] attempt_t;

  typedef logic [1:0] credit_t;

  // first seed digit sits in the top nibble
  typedef logic [15:0] lfsr_t;

  typedef struct packed {
    count_t   strike;
    count_t   ball;
    attempt_t attempt;   // 1..10
    logic     win;
    logic     lose;
    logic [2:0] pad;     // always zero
  } report_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ENTRY,
    ST_SCORE,
    ST_DONE
  } game_state_e;

endpackage

// ==== rtl/baseball_top.sv ====
// top level of the number baseball game, keypad in and credited reports out
`timescale 1ns/100ps

module baseball_top import baseball_pkg::*; (
  input  logic                   clk,
  input  logic                   sharp_rst,
  input  keypad_t                i_numpad,
  input  logic                   i_star,
  input  logic                   i_seed_mode,
  input  logic                   i_credit_return,
  output logic [SEED_DIGITS-1:0] o_seed_mask,
  output logic                   o_secret_ready,
  output logic                   o_report_valid,
  output report_t                o_report
);

  digit_t                    digit;
  logic                      seed_commit;
  logic                      guess_commit;
  logic                      seed_load;
  lfsr_t                     seed_value;
  digit_t [GUESS_DIGITS-1:0] secret;
  logic                      clear;
  logic                      push;
  report_t                   push_report;
  logic                      can_send;

  key_capture u_keys (
    .clk            (clk),
    .sharp_rst      (sharp_rst),
    .i_numpad       (i_numpad),
    .i_star         (i_star),
    .i_seed_mode    (i_seed_mode),
    .o_digit        (digit),
    .o_seed_commit  (seed_commit),
    .o_guess_commit (guess_commit)
  );

  seed_regs u_seed (
    .clk          (clk),
    .sharp_rst    (sharp_rst),
    .i_commit     (seed_commit),
    .i_digit      (digit),
    .i_clear      (clear),
    .o_seed_mask  (o_seed_mask),
    .o_seed_load  (seed_load),
    .o_seed_value (seed_value)
  );

  secret_gen u_secret (
    .clk            (clk),
    .sharp_rst      (sharp_rst),
    .i_load         (seed_load),
    .i_seed         (seed_value),
    .i_clear        (clear),
    .o_secret_valid (o_secret_ready),
    .o_secret       (secret)
  );

  game_fsm u_game (
    .clk            (clk),
    .sharp_rst      (sharp_rst),
    .i_commit       (guess_commit),
    .i_digit        (digit),
    .i_secret_valid (o_secret_ready),
    .i_secret       (secret),
    .i_can_send     (can_send),
    .o_push         (push),
    .o_report       (push_report),
    .o_clear        (clear)
  );

  report_credit u_report (
    .clk             (clk),
    .sharp_rst       (sharp_rst),
    .i_push          (push),
    .i_report        (push_report),
    .i_credit_return (i_credit_return),
    .o_can_send      (can_send),
    .o_report_valid  (o_report_valid),
    .o_report        (o_report)
  );

endmodule

// ==== rtl/game_fsm.sv ====
// game controller, collects guesses, scores strikes and balls and decides win or loss
`timescale 1ns/100ps

module game_fsm import baseball_pkg::*; (
  input  logic                       clk,
  input  logic                       sharp_rst,
  input  logic                       i_commit,
  input  digit_t                     i_digit,
  input  logic                       i_secret_valid,
  input  digit_t [GUESS_DIGITS-1:0]  i_secret,
  input  logic                       i_can_send,
  output logic                       o_push,
  output report_t                    o_report,
  output logic                       o_clear
);

  localparam int CW = $clog2(GUESS_DIGITS + 1);

  game_state_e               state_q;
  digit_t [GUESS_DIGITS-1:0] guess_q;
  logic [CW-1:0]             cnt_q;      // accepted digits in this guess
  attempt_t                  attempt_q;  // scored guesses so far
  logic                      accept;
  logic                      dup;
  count_t                    strike;
  count_t                    ball;
  report_t                   report_next;
  logic                      ending;

  // a digit may appear only once per guess
  always_comb begin
    dup = 1'b0;
    for (int k = 0; k < GUESS_DIGITS; k++) begin
      if (k < cnt_q && guess_q[k] == i_digit) dup = 1'b1;
    end
    accept = (state_q == ST_ENTRY) && i_commit && (i_digit != '0) && !dup;
  end

  always_comb begin
    strike = '0;
    ball   = '0;
    for (int i = 0; i < GUESS_DIGITS; i++) begin
      for (int j = 0; j < GUESS_DIGITS; j++) begin
        if (guess_q[i] == i_secret[j]) begin
          if (i == j) strike = strike + 1'b1;
          else        ball   = ball + 1'b1;
        end
      end
    end
  end

  always_comb begin
    report_next         = '0;
    report_next.strike  = strike;
    report_next.ball    = ball;
    report_next.attempt = attempt_q + 1'b1;
    report_next.win     = (strike == GUESS_DIGITS);
    report_next.lose    = !report_next.win &&
                          (report_next.attempt == attempt_t'(MAX_ATTEMPTS));
  end

  assign ending  = report_next.win || report_next.lose;
  assign o_clear = (state_q == ST_DONE);

  always_ff @(posedge clk) begin
    if (!sharp_rst) begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      attempt_q <= '0;
      o_push    <= 1'b0;
    end else begin
      o_push <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (i_secret_valid) state_q <= ST_ENTRY;
        end
        ST_ENTRY: begin
          if (accept) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == GUESS_DIGITS - 1) state_q <= ST_SCORE;
          end
        end
        ST_SCORE: begin
          if (i_can_send) begin   // wait here for credit
            o_push    <= 1'b1;
            attempt_q <= attempt_q + 1'b1;
            cnt_q     <= '0;
            state_q   <= ending ? ST_DONE : ST_ENTRY;
          end
        end
        ST_DONE: begin
          attempt_q <= '0;
          state_q   <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) guess_q[cnt_q] <= i_digit;
    if (state_q == ST_SCORE && i_can_send) o_report <= report_next;
  end

  a_push_credit: assert property (@(posedge clk) disable iff (!sharp_rst)
    o_push |-> i_can_send);

endmodule

// ==== rtl/key_capture.sv ====
// keypad front end, latches the pressed digit and turns star edges into commit pulses
`timescale 1ns/100ps

module key_capture import baseball_pkg::*; (
  input  logic    clk,
  input  logic    sharp_rst,
  input  keypad_t i_numpad,
  input  logic    i_star,
  input  logic    i_seed_mode,
  output digit_t  o_digit,
  output logic    o_seed_commit,
  output logic    o_guess_commit
);

  digit_t decoded;
  logic   star_q;
  logic   star_rise;

  always_comb begin
    decoded = '0;
    for (int k = 0; k < KEYS; k++) begin
      if (i_numpad[k]) decoded = digit_t'(k);
    end
  end

  assign star_rise = i_star && !star_q;

  always_ff @(posedge clk) begin
    if (!sharp_rst) begin
      o_digit        <= '0;
      star_q         <= 1'b0;
      o_seed_commit  <= 1'b0;
      o_guess_commit <= 1'b0;
    end else begin
      star_q         <= i_star;
      o_seed_commit  <= star_rise && i_seed_mode;
      o_guess_commit <= star_rise && !i_seed_mode;
      if (i_numpad != '0 && !i_star) o_digit <= decoded;   // no latch while star held
    end
  end

  a_keypad_onehot: assert property (@(posedge clk) disable iff (!sharp_rst)
    $onehot0(i_numpad));

endmodule

// ==== rtl/report_credit.sv ====
// report output stage, registers each report and tracks credits from the display consumer
`timescale 1ns/100ps

module report_credit import baseball_pkg::*; (
  input  logic    clk,
  input  logic    sharp_rst,
  input  logic    i_push,
  input  report_t i_report,
  input  logic    i_credit_return,
  output logic    o_can_send,
  output logic    o_report_valid,
  output report_t o_report
);

  credit_t credit_q;

  assign o_can_send = (credit_q != '0);

  always_ff @(posedge clk) begin
    if (!sharp_rst) begin
      credit_q       <= credit_t'(REPORT_CREDITS);
      o_report_valid <= 1'b0;
    end else begin
      o_report_valid <= i_push;   // single-beat report
      case ({i_push, i_credit_return})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;   // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) o_report <= i_report;
  end

  a_credit_max: assert property (@(posedge clk) disable iff (!sharp_rst)
    credit_q <= credit_t'(REPORT_CREDITS));

endmodule

// ==== rtl/secret_gen.sv ====
// secret generator, steps the seeded LFSR and folds it into three distinct digits 1..9
`timescale 1ns/100ps

module secret_gen import baseball_pkg::*; (
  input  logic                       clk,
  input  logic                       sharp_rst,
  input  logic                       i_load,
  input  lfsr_t                      i_seed,
  input  logic                       i_clear,
  output logic                       o_secret_valid,
  output digit_t [GUESS_DIGITS-1:0]  o_secret
);

  lfsr_t                     state_q;
  lfsr_t                     stepped;
  logic                      step_q;
  digit_t [GUESS_DIGITS-1:0] folded;

  function automatic digit_t bump(input digit_t d);
    return digit_t'((d % 9) + 1);
  endfunction

  always_comb begin
    stepped = {state_q[14:0], state_q[15] ^ state_q[13] ^ state_q[12] ^ state_q[10]};
    for (int i = 0; i < GUESS_DIGITS; i++) begin
      folded[i] = bump(stepped[15-4*i -: 4]);
    end
    // three passes settle any collision
    for (int p = 0; p < 3; p++) begin
      if (folded[0] == folded[1]) folded[0] = bump(folded[0]);
      if (folded[0] == folded[2]) folded[0] = bump(folded[0]);
      if (folded[1] == folded[2]) folded[1] = bump(folded[1]);
    end
  end

  always_ff @(posedge clk) begin
    if (!sharp_rst || i_clear) begin
      step_q         <= 1'b0;
      o_secret_valid <= 1'b0;
    end else begin
      step_q <= i_load;
      if (step_q) o_secret_valid <= 1'b1;   // held until the game ends
    end
  end

  always_ff @(posedge clk) begin
    if (i_load) begin
      state_q <= i_seed;
    end
    if (step_q) o_secret <= folded;
  end

  a_secret_ok: assert property (@(posedge clk) disable iff (!sharp_rst)
    o_secret_valid |-> (o_secret[0] != '0 && o_secret[1] != '0 && o_secret[2] != '0 &&
                        o_secret[0] != o_secret[1] && o_secret[0] != o_secret[2] &&
                        o_secret[1] != o_secret[2]));

endmodule

// ==== rtl/seed_regs.sv ====
// seed configuration registers, fills four seed slots in order and hands the seed to the LFSR
`timescale 1ns/100ps

module seed_regs import baseball_pkg::*; (
  input  logic                   clk,
  input  logic                   sharp_rst,
  input  logic                   i_commit,
  input  digit_t                 i_digit,
  input  logic                   i_clear,
  output logic [SEED_DIGITS-1:0] o_seed_mask,
  output logic                   o_seed_load,
  output lfsr_t                  o_seed_value
);

  digit_t [SEED_DIGITS-1:0]         seed_q;
  logic [$clog2(SEED_DIGITS)-1:0]   slot;
  logic                             full;
  logic                             full_q;
  logic                             take;

  assign full = &o_seed_mask;
  assign take = i_commit && (i_digit != '0) && !full;   // digit 0 fills nothing

  // first empty slot, flags fill from bit 0 upward
  always_comb begin
    slot = '0;
    for (int k = SEED_DIGITS - 1; k >= 0; k--) begin
      if (!o_seed_mask[k]) slot = k[$clog2(SEED_DIGITS)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!sharp_rst || i_clear) begin
      o_seed_mask <= '0;
      o_seed_load <= 1'b0;
      full_q      <= 1'b0;
    end else begin
      full_q      <= full;
      o_seed_load <= full && !full_q;   // one pulse per completed seed
      if (take) o_seed_mask[slot] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take) seed_q[SEED_DIGITS-1-slot] <= i_digit;
  end

  assign o_seed_value = seed_q;   // slot 0 lands in the top nibble

  a_load_full: assert property (@(posedge clk) disable iff (!sharp_rst)
    o_seed_load |-> ((&o_seed_mask) && seed_q[0] != '0 && seed_q[1] != '0 &&
                     seed_q[2] != '0 && seed_q[3] != '0));

endmodule

// ==== verification/baseball_tb.sv ====
// testbench for baseball_top, replays verification/baseball_trace.txt and checks every report
`timescale 1ns/100ps

module baseball_tb import baseball_pkg::*; ();

  localparam int REPORT_WAIT = 20;   // cycles allowed for a report or a ready change
  localparam int KEY_CYCLES  = 8;
  localparam int MARGIN      = 200;

  logic                   clk;
  logic                   sharp_rst;
  keypad_t                i_numpad;
  logic                   i_star;
  logic                   i_seed_mode;
  logic                   i_credit_return;
  logic [SEED_DIGITS-1:0] o_seed_mask;
  logic                   o_secret_ready;
  logic                   o_report_valid;
  report_t                o_report;

  report_t seen[$];
  string   lines[$];
  int      cycles = 0;
  int      limit = 0;
  int      errors = 0;
  int      test_errors = 0;
  int      tests = 0;
  int      failed_tests = 0;
  bit      auto_credit;

  baseball_top uut (
    .clk             (clk),
    .sharp_rst       (sharp_rst),
    .i_numpad        (i_numpad),
    .i_star          (i_star),
    .i_seed_mode     (i_seed_mode),
    .i_credit_return (i_credit_return),
    .o_seed_mask     (o_seed_mask),
    .o_secret_ready  (o_secret_ready),
    .o_report_valid  (o_report_valid),
    .o_report        (o_report)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (o_report_valid) seen.push_back(o_report);   // every report beat
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout, the trace did not finish within %0d cycles", limit);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input int exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic apply_reset();
    sharp_rst = 1'b0;
    repeat (10) @(negedge clk);
    sharp_rst = 1'b1;
  endtask

  task automatic press_key(input int d);
    i_numpad = keypad_t'(1 << d);
    repeat (2) @(negedge clk);
    i_numpad = '0;
    repeat (2) @(negedge clk);
    i_star = 1'b1;
    repeat (2) @(negedge clk);
    i_star = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic pulse_credit();
    i_credit_return = 1'b1;
    @(negedge clk);
    i_credit_return = 1'b0;
  endtask

  task automatic expect_report(input int s, input int b, input int a, input int w, input int l);
    report_t r;
    int      waited;
    waited = 0;
    while (seen.size() == 0 && waited < REPORT_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (seen.size() == 0) begin
      $display("no report arrived within %0d cycles at %0t, FSM in %s",
               REPORT_WAIT, $time, uut.u_game.state_q.name());
      test_errors++;
    end else begin
      r = seen.pop_front();
      check_value("o_report.strike", r.strike, s);
      check_value("o_report.ball", r.ball, b);
      check_value("o_report.attempt", r.attempt, a);
      check_value("o_report.win", r.win, w);
      check_value("o_report.lose", r.lose, l);
      check_value("o_report.pad", r.pad, 0);
      if (auto_credit) pulse_credit();   // consumer hands the credit back
    end
  endtask

  task automatic expect_ready(input int r);
    int waited;
    waited = 0;
    while (o_secret_ready !== r[0] && waited < REPORT_WAIT) begin
      @(negedge clk);
      waited++;
    end
    check_value("o_secret_ready", o_secret_ready, r);
  endtask

  task automatic expect_empty();
    if (seen.size() != 0 || o_report_valid !== 1'b0) begin
      $display("unexpected report at %0t, %0d reports queued", $time, seen.size());
      test_errors++;
      seen.delete();
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: FAIL with %0d errors", name, test_errors);
      failed_tests++;
    end
    test_errors = 0;
  endtask

  task automatic load_trace(input int fd);
    string line;
    string cmd;
    string arg;
    int    n;
    limit = MARGIN;
    while ($fgets(line, fd) > 0) begin
      lines.push_back(line);
      n = $sscanf(line, "%s %s", cmd, arg);
      if (n >= 1 && cmd == "reset") limit += 10;
      if (n == 2 && cmd == "key") limit += KEY_CYCLES * arg.len();
      if (n == 2 && cmd == "wait") limit += arg.atoi();
    end
    $fclose(fd);
  endtask

  task automatic run_trace();
    string cmd;
    string arg;
    int    v[5];
    foreach (lines[i]) begin
      if ($sscanf(lines[i], "%s", cmd) != 1 || cmd.getc(0) == "#") continue;
      void'($sscanf(lines[i], "%s %s", cmd, arg));
      if (cmd == "reset") begin
        apply_reset();
      end else if (cmd == "mode") begin
        i_seed_mode = (arg.atoi() != 0);
      end else if (cmd == "key") begin
        for (int k = 0; k < arg.len(); k++) press_key(arg.substr(k, k).atoi());
      end else if (cmd == "credit") begin
        if (arg == "pulse") pulse_credit();
        else auto_credit = (arg == "auto");
      end else if (cmd == "wait") begin
        repeat (arg.atoi()) @(negedge clk);
      end else if (cmd == "expect_report") begin
        void'($sscanf(lines[i], "%s %d %d %d %d %d", cmd, v[0], v[1], v[2], v[3], v[4]));
        expect_report(v[0], v[1], v[2], v[3], v[4]);
      end else if (cmd == "expect_mask") begin
        void'($sscanf(lines[i], "%s %h", cmd, v[0]));
        check_value("o_seed_mask", o_seed_mask, v[0]);
      end else if (cmd == "expect_ready") begin
        expect_ready(arg.atoi());
      end else if (cmd == "expect_empty") begin
        expect_empty();
      end else if (cmd == "end") begin
        finish_test(arg);
      end else begin
        $display("unknown trace command %s on line %0d", cmd, i + 1);
        test_errors++;
      end
    end
  endtask

  initial begin
    int fd;
    clk             = 1'b0;
    sharp_rst       = 1'b0;
    i_numpad        = '0;
    i_star          = 1'b0;
    i_seed_mode     = 1'b0;
    i_credit_return = 1'b0;
    auto_credit     = 1'b1;
    fd = $fopen("verification/baseball_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file verification/baseball_trace.txt");
      $display("Test failures found");
      $finish;
    end else begin
      load_trace(fd);
      @(negedge clk);
      run_trace();
      errors += test_errors;
      $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

endmodule

// ==== verification/baseball_trace.txt ====
# command and arguments: reset, mode m, key digits, credit pulse|hold|auto, wait n,
# expect_report s b attempt win lose, expect_mask hex, expect_ready r, expect_empty, end name
reset
expect_mask 0
expect_ready 0
mode 1
key 1
expect_mask 1
key 0
expect_mask 1
key 2
expect_mask 3
key 3
expect_mask 7
key 4
expect_mask f
expect_ready 1
end seed_entry
mode 0
key 357
expect_report 3 0 1 1 0
expect_ready 0
expect_mask 0
mode 1
key 1111
expect_ready 1
mode 0
key 543
expect_report 3 0 1 1 0
expect_ready 0
expect_mask 0
end secret_derivation
mode 1
key 9876
expect_ready 1
mode 0
key 146
expect_report 1 2 1 0 0
key 40421
expect_report 1 1 2 0 0
key 641
expect_report 0 3 3 0 0
key 235
expect_report 0 0 4 0 0
key 416
expect_report 3 0 5 1 0
expect_ready 0
end scoring
mode 1
key 1234
expect_ready 1
mode 0
key 124
expect_report 0 0 1 0 0
key 324
expect_report 1 0 2 0 0
key 531
expect_report 0 2 3 0 0
key 735
expect_report 0 3 4 0 0
key 358
expect_report 2 0 5 0 0
key 124
expect_report 0 0 6 0 0
key 986
expect_report 0 0 7 0 0
key 375
expect_report 1 2 8 0 0
key 573
expect_report 0 3 9 0 0
key 359
expect_report 2 0 10 0 1
expect_ready 0
expect_mask 0
end loss
mode 1
key 1234
expect_ready 1
mode 0
credit hold
key 124
expect_report 0 0 1 0 0
key 753
expect_report 1 2 2 0 0
key 389
key 9
wait 10
expect_empty
credit pulse
expect_report 1 0 3 0 0
wait 5
expect_empty
credit pulse
credit pulse
credit auto
key 357
expect_report 3 0 4 1 0
expect_ready 0
end credit_backpressure
mode 1
key 9876
expect_ready 1
mode 0
key 14
reset
expect_mask 0
expect_ready 0
expect_empty
mode 1
key 1111
expect_ready 1
mode 0
key 534
expect_report 1 2 1 0 0
key 543
expect_report 3 0 2 1 0
end reset_mid_game
